// ==== little_computer_pkg.sv ====
package little_computer_pkg;

	// Data path and memory sizes
	localparam int word_width = 16;
	localparam int addr_width = 8;
	localparam int mem_depth = 256;
	localparam int reg_count = 8;

	// 50 MHz / 115200 baud
	localparam int clks_per_bit = 434;
	localparam int baud_cnt_width = $clog2(clks_per_bit);

	// Free-running step rate, one step every step_div clocks
	localparam int step_div = 64;
	localparam int step_div_width = $clog2(step_div);

	// Opcodes in bits 15..12, unlisted codes run as no-ops
	typedef enum logic [3:0] {
		op_add  = 4'h0,
		op_sub  = 4'h1,
		op_and  = 4'h2,
		op_ldi  = 4'h3,
		op_ld   = 4'h4,
		op_st   = 4'h5,
		op_beqz = 4'h6,
		op_halt = 4'h7
	} opcode_t;

	typedef enum logic {
		cpu_run,
		cpu_halted
	} cpu_state_t;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx import little_computer_pkg::*; (
	input  logic       MAX10_CLK1_50,
	input  logic       rst,
	input  logic       uart_line,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	logic line_s1;
	logic line_s2;
	logic line_s3;
	rx_state_t state;
	logic [baud_cnt_width-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;

	logic bit_end;
	logic half_end;

	assign bit_end = (cnt == baud_cnt_width'(clks_per_bit - 1));
	assign half_end = (cnt == baud_cnt_width'(clks_per_bit / 2 - 1));
	assign rx_byte = shift;

	// A start needs a real falling edge, so a frame with a low stop bit
	// cannot re-trigger until the line has gone high again
	always_ff @(posedge MAX10_CLK1_50 or negedge rst) begin
		if (!rst) begin
			line_s1 <= 1'b1;
			line_s2 <= 1'b1;
			line_s3 <= 1'b1;
			state <= rx_idle;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			line_s1 <= uart_line;
			line_s2 <= line_s1;
			line_s3 <= line_s2;
			rx_valid <= 1'b0;
			case (state)
				rx_idle: begin
					cnt <= '0;
					if (line_s3 && !line_s2)
						state <= rx_start;
				end
				rx_start: begin
					if (half_end) begin
						cnt <= '0;
						bit_idx <= '0;
						// Glitch shorter than half a bit
						state <= line_s2 ? rx_idle : rx_data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				rx_data: begin
					if (bit_end) begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				rx_stop: begin
					if (bit_end) begin
						cnt <= '0;
						rx_valid <= line_s2;
						state <= rx_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// LSB first, so each new bit enters at the top
	always_ff @(posedge MAX10_CLK1_50) begin
		if (state == rx_data && bit_end)
			shift <= {line_s2, shift[7:1]};
	end

endmodule

// ==== uart_word_loader.sv ====
`timescale 1ns/1ns

module uart_word_loader import little_computer_pkg::*; (
	input  logic                  MAX10_CLK1_50,
	input  logic                  rst,
	input  logic                  load_en,
	input  logic [7:0]            rx_byte,
	input  logic                  rx_valid,
	output logic                  load_we,
	output logic [addr_width-1:0] load_addr,
	output logic [word_width-1:0] load_word
);

	logic [7:0] high_byte;
	// High when the next byte completes a word
	logic phase;

	always_ff @(posedge MAX10_CLK1_50 or negedge rst) begin
		if (!rst) begin
			phase <= 1'b0;
			load_we <= 1'b0;
			load_addr <= '0;
		end else if (!load_en) begin
			phase <= 1'b0;
			load_we <= 1'b0;
			load_addr <= '0;
		end else begin
			load_we <= 1'b0;
			if (rx_valid) begin
				phase <= ~phase;
				load_we <= phase;
			end
			// Address moves on once the memory has taken the word
			if (load_we)
				load_addr <= load_addr + 1'b1;
		end
	end

	always_ff @(posedge MAX10_CLK1_50) begin
		if (load_en && rx_valid) begin
			if (phase)
				load_word <= {high_byte, rx_byte};
			else
				high_byte <= rx_byte;
		end
	end

endmodule

// ==== step_control.sv ====
`timescale 1ns/1ns

module step_control import little_computer_pkg::*; (
	input  logic MAX10_CLK1_50,
	input  logic rst,
	input  logic debug_mode,
	input  logic step_key_n,
	output logic step
);

	logic key_s1;
	logic key_s2;
	logic key_d;
	logic key_fall;
	logic [step_div_width-1:0] div_cnt;
	logic div_tick;

	assign key_fall = key_d && !key_s2;
	assign div_tick = (div_cnt == step_div_width'(step_div - 1));

	always_ff @(posedge MAX10_CLK1_50 or negedge rst) begin
		if (!rst) begin
			key_s1 <= 1'b1;
			key_s2 <= 1'b1;
			key_d <= 1'b1;
			div_cnt <= '0;
			step <= 1'b0;
		end else begin
			key_s1 <= step_key_n;
			key_s2 <= key_s1;
			key_d <= key_s2;
			div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
			// Key press in debug mode, divider otherwise
			step <= debug_mode ? key_fall : div_tick;
		end
	end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/1ns

module cpu_core import little_computer_pkg::*; (
	input  logic                  MAX10_CLK1_50,
	input  logic                  rst,
	input  logic                  load_en,
	input  logic                  step,
	input  logic [word_width-1:0] instr,
	input  logic [word_width-1:0] data_rdata,
	output logic [addr_width-1:0] pc,
	output logic [addr_width-1:0] data_addr,
	output logic [word_width-1:0] cpu_wdata,
	output logic                  cpu_we,
	output logic [word_width-1:0] r7,
	output logic                  halted
);

	logic [word_width-1:0] regs [reg_count];
	cpu_state_t state;

	opcode_t op;
	logic [2:0] rd;
	logic [2:0] rs;
	logic [2:0] rt;
	logic [word_width-1:0] imm9_ext;
	logic [addr_width-1:0] off6_ext;
	logic exec;
	logic [addr_width-1:0] pc_next;

	assign op = opcode_t'(instr[15:12]);
	assign rd = instr[11:9];
	assign rs = instr[8:6];
	assign rt = instr[5:3];
	assign imm9_ext = {{(word_width - 9){1'b0}}, instr[8:0]};
	assign off6_ext = {{(addr_width - 6){instr[5]}}, instr[5:0]};

	// One instruction retires on each accepted step
	assign exec = step && !load_en && (state == cpu_run);

	assign data_addr = regs[rs][addr_width-1:0];
	assign cpu_wdata = regs[rd];
	assign cpu_we = exec && (op == op_st);

	assign r7 = regs[7];
	assign halted = (state == cpu_halted);

	always_comb begin
		pc_next = pc + 1'b1;
		case (op)
			op_beqz: begin
				if (regs[rd] == '0)
					pc_next = pc + 1'b1 + off6_ext;
			end
			// pc stays on the halt word so the display keeps showing it
			op_halt: pc_next = pc;
			default: pc_next = pc + 1'b1;
		endcase
	end

	always_ff @(posedge MAX10_CLK1_50 or negedge rst) begin
		if (!rst) begin
			pc <= '0;
			state <= cpu_run;
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (load_en) begin
			pc <= '0;
			state <= cpu_run;
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (exec) begin
			pc <= pc_next;
			case (op)
				op_add: regs[rd] <= regs[rs] + regs[rt];
				op_sub: regs[rd] <= regs[rs] - regs[rt];
				op_and: regs[rd] <= regs[rs] & regs[rt];
				op_ldi: regs[rd] <= imm9_ext;
				op_ld: regs[rd] <= data_rdata;
				op_halt: state <= cpu_halted;
				// Store goes out through cpu_we, branch only moves pc
				default: state <= cpu_run;
			endcase
		end
	end

endmodule

// ==== unified_memory.sv ====
`timescale 1ns/1ns

module unified_memory import little_computer_pkg::*; (
	input  logic                  MAX10_CLK1_50,
	input  logic                  load_en,
	input  logic [addr_width-1:0] pc,
	output logic [word_width-1:0] instr,
	input  logic [addr_width-1:0] data_addr,
	output logic [word_width-1:0] data_rdata,
	input  logic                  load_we,
	input  logic [addr_width-1:0] load_addr,
	input  logic [word_width-1:0] load_word,
	input  logic                  cpu_we,
	input  logic [word_width-1:0] cpu_wdata
);

	logic [word_width-1:0] mem [mem_depth];

	logic                  wr_en;
	logic [addr_width-1:0] wr_addr;
	logic [word_width-1:0] wr_data;

	// Loader owns the write port while loading, the CPU otherwise
	assign wr_en = load_en ? load_we : cpu_we;
	assign wr_addr = load_en ? load_addr : data_addr;
	assign wr_data = load_en ? load_word : cpu_wdata;

	// Both reads are asynchronous
	assign instr = mem[pc];
	assign data_rdata = mem[data_addr];

	always_ff @(posedge MAX10_CLK1_50) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

endmodule

// ==== hex_display.sv ====
`timescale 1ns/1ns

module hex_display import little_computer_pkg::*; (
	input  logic                  debug_mode,
	input  logic [addr_width-1:0] pc,
	input  logic [word_width-1:0] instr,
	output logic [7:0]            hex0,
	output logic [7:0]            hex1,
	output logic [7:0]            hex2,
	output logic [7:0]            hex3,
	output logic [7:0]            hex4,
	output logic [7:0]            hex5
);

	// Active-low segments, bit 7 is the decimal point and stays off
	function automatic logic [7:0] seg7(input logic [3:0] nib);
		logic [6:0] gfedcba;
		case (nib)
			4'h0: gfedcba = 7'b1000000;
			4'h1: gfedcba = 7'b1111001;
			4'h2: gfedcba = 7'b0100100;
			4'h3: gfedcba = 7'b0110000;
			4'h4: gfedcba = 7'b0011001;
			4'h5: gfedcba = 7'b0010010;
			4'h6: gfedcba = 7'b0000010;
			4'h7: gfedcba = 7'b1111000;
			4'h8: gfedcba = 7'b0000000;
			4'h9: gfedcba = 7'b0010000;
			4'ha: gfedcba = 7'b0001000;
			4'hb: gfedcba = 7'b0000011;
			4'hc: gfedcba = 7'b1000110;
			4'hd: gfedcba = 7'b0100001;
			4'he: gfedcba = 7'b0000110;
			default: gfedcba = 7'b0001110;
		endcase
		return {1'b1, gfedcba};
	endfunction

	// Blank digits are all ones
	assign hex0 = debug_mode ? seg7(instr[3:0]) : 8'hff;
	assign hex1 = debug_mode ? seg7(instr[7:4]) : 8'hff;
	assign hex2 = debug_mode ? seg7(instr[11:8]) : 8'hff;
	assign hex3 = debug_mode ? seg7(instr[15:12]) : 8'hff;
	assign hex4 = debug_mode ? seg7(pc[3:0]) : 8'hff;
	assign hex5 = debug_mode ? seg7(pc[7:4]) : 8'hff;

endmodule

// ==== little_computer.sv ====
`timescale 1ns/1ns

module little_computer import little_computer_pkg::*; (
	input  logic       MAX10_CLK1_50,
	input  logic       rst,
	input  logic       uart_line,
	input  logic       step_key_n,
	input  logic       debug_mode,
	input  logic       load_en,
	output logic [7:0] hex0,
	output logic [7:0] hex1,
	output logic [7:0] hex2,
	output logic [7:0] hex3,
	output logic [7:0] hex4,
	output logic [7:0] hex5,
	output logic [9:0] ledr
);

	logic [7:0]            rx_byte;
	logic                  rx_valid;
	logic                  load_we;
	logic [addr_width-1:0] load_addr;
	logic [word_width-1:0] load_word;
	logic                  step;
	logic [addr_width-1:0] pc;
	logic [word_width-1:0] instr;
	logic [addr_width-1:0] data_addr;
	logic [word_width-1:0] data_rdata;
	logic [word_width-1:0] cpu_wdata;
	logic                  cpu_we;
	logic [word_width-1:0] r7;
	logic                  halted;

	// Input side
	uart_rx u_uart_rx (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst           (rst),
		.uart_line     (uart_line),
		.rx_byte       (rx_byte),
		.rx_valid      (rx_valid)
	);

	uart_word_loader u_loader (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst           (rst),
		.load_en       (load_en),
		.rx_byte       (rx_byte),
		.rx_valid      (rx_valid),
		.load_we       (load_we),
		.load_addr     (load_addr),
		.load_word     (load_word)
	);

	step_control u_step (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst           (rst),
		.debug_mode    (debug_mode),
		.step_key_n    (step_key_n),
		.step          (step)
	);

	// Processing part
	cpu_core u_cpu (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst           (rst),
		.load_en       (load_en),
		.step          (step),
		.instr         (instr),
		.data_rdata    (data_rdata),
		.pc            (pc),
		.data_addr     (data_addr),
		.cpu_wdata     (cpu_wdata),
		.cpu_we        (cpu_we),
		.r7            (r7),
		.halted        (halted)
	);

	unified_memory u_mem (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.load_en       (load_en),
		.pc            (pc),
		.instr         (instr),
		.data_addr     (data_addr),
		.data_rdata    (data_rdata),
		.load_we       (load_we),
		.load_addr     (load_addr),
		.load_word     (load_word),
		.cpu_we        (cpu_we),
		.cpu_wdata     (cpu_wdata)
	);

	// Output side
	hex_display u_hex (
		.debug_mode (debug_mode),
		.pc         (pc),
		.instr      (instr),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5)
	);

	assign ledr = {halted, 1'b0, r7[7:0]};

endmodule

// ==== little_computer_checker.sv ====
`timescale 1ns/1ns

module little_computer_checker import little_computer_pkg::*; (
	input  logic                  MAX10_CLK1_50,
	input  logic                  check_hex,
	input  logic                  check_led,
	input  logic [addr_width-1:0] exp_pc,
	input  logic [word_width-1:0] exp_instr,
	input  logic [7:0]            exp_r7_low,
	input  logic                  exp_halt,
	input  logic                  debug_mode,
	input  logic [7:0]            hex0,
	input  logic [7:0]            hex1,
	input  logic [7:0]            hex2,
	input  logic [7:0]            hex3,
	input  logic [7:0]            hex4,
	input  logic [7:0]            hex5,
	input  logic [9:0]            ledr,
	output int                    check_count,
	output int                    error_count
);

	int checks = 0;
	int errors = 0;

	assign check_count = checks;
	assign error_count = errors;

	// Segments a..g in bits 0..6, lit high
	function automatic logic [7:0] digit_segments(input logic [3:0] value);
		logic [6:0] lit;
		case (value)
			4'h0: lit = 7'h3f;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5b;
			4'h3: lit = 7'h4f;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6d;
			4'h6: lit = 7'h7d;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7f;
			4'h9: lit = 7'h6f;
			4'ha: lit = 7'h77;
			4'hb: lit = 7'h7c;
			4'hc: lit = 7'h39;
			4'hd: lit = 7'h5e;
			4'he: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		// Board digits are active low, decimal point dark
		return {1'b1, ~lit};
	endfunction

	always @(posedge MAX10_CLK1_50) begin
		logic [7:0] got [6];
		logic [23:0] shown;
		logic [7:0] want;
		got[0] = hex0;
		got[1] = hex1;
		got[2] = hex2;
		got[3] = hex3;
		got[4] = hex4;
		got[5] = hex5;
		// pc on the two left digits, instruction on the right four
		shown = {exp_pc, exp_instr};
		if (check_hex) begin
			checks++;
			for (int i = 0; i < 6; i++) begin
				want = debug_mode ? digit_segments(shown[4*i +: 4]) : 8'hff;
				if (got[i] !== want) begin
					$display("ERROR %0t ns: hex%0d is %h, expected %h", $time, i, got[i], want);
					errors++;
				end
			end
		end
		if (check_led) begin
			checks++;
			if (ledr[7:0] !== exp_r7_low) begin
				$display("ERROR %0t ns: ledr[7:0] is %h, expected r7 low byte %h",
					$time, ledr[7:0], exp_r7_low);
				errors++;
			end
			if (ledr[9:8] !== {exp_halt, 1'b0}) begin
				$display("ERROR %0t ns: ledr[9:8] is %b, expected %b",
					$time, ledr[9:8], {exp_halt, 1'b0});
				errors++;
			end
		end
	end

endmodule

// ==== little_computer_assert.sv ====
`timescale 1ns/1ns

module little_computer_assert import little_computer_pkg::*; (
	input logic                  MAX10_CLK1_50,
	input logic                  rst,
	input logic                  load_en,
	input logic                  step,
	input logic [addr_width-1:0] pc,
	input logic                  cpu_we,
	input logic [word_width-1:0] r7,
	input logic                  halted
);

	int unsigned failures = 0;

	// A step during loading retires nothing, pc and registers stay cleared
	no_step_while_loading: assert property (@(posedge MAX10_CLK1_50) disable iff (!rst)
		(step && load_en) |=> (pc == '0 && r7 == '0))
		else begin
			$error("A step changed pc or r7 while load_en is high");
			failures++;
		end

	pc_frozen_when_halted: assert property (@(posedge MAX10_CLK1_50) disable iff (!rst)
		(halted && !load_en) |=> $stable(pc))
		else begin
			$error("pc moved while the CPU is halted");
			failures++;
		end

	store_is_one_cycle: assert property (@(posedge MAX10_CLK1_50) disable iff (!rst)
		cpu_we |=> !cpu_we)
		else begin
			$error("cpu_we held longer than one cycle");
			failures++;
		end

endmodule

bind cpu_core little_computer_assert cpu_checks (
	.MAX10_CLK1_50 (MAX10_CLK1_50),
	.rst           (rst),
	.load_en       (load_en),
	.step          (step),
	.pc            (pc),
	.cpu_we        (cpu_we),
	.r7            (r7),
	.halted        (halted)
);

// ==== tb_little_computer.sv ====
`timescale 1ns/1ns

module tb_little_computer import little_computer_pkg::*; ();

	logic       MAX10_CLK1_50 = 1'b0;
	logic       rst;
	logic       uart_line;
	logic       step_key_n;
	logic       debug_mode;
	logic       load_en;
	logic [7:0] hex0;
	logic [7:0] hex1;
	logic [7:0] hex2;
	logic [7:0] hex3;
	logic [7:0] hex4;
	logic [7:0] hex5;
	logic [9:0] ledr;

	// Requests and expected values handed to the checker
	logic                  check_hex;
	logic                  check_led;
	logic [addr_width-1:0] exp_pc;
	logic [word_width-1:0] exp_instr;
	logic [7:0]            exp_r7_low;
	logic                  exp_halt;
	int                    check_count;
	int                    error_count;
	int                    timeouts;

	// Reference model state
	logic [word_width-1:0] model_mem [mem_depth];
	logic [word_width-1:0] model_regs [reg_count];
	logic [addr_width-1:0] model_pc;
	logic                  model_halt;
	logic [word_width-1:0] image [$];

	always #2 MAX10_CLK1_50 = ~MAX10_CLK1_50;

	little_computer dut (.*);

	little_computer_checker u_checker (.*);

	function automatic logic [15:0] encode_reg(input opcode_t op, input logic [2:0] rd,
		input logic [2:0] rs, input logic [2:0] rt);
		return {op, rd, rs, rt, 3'b000};
	endfunction

	function automatic logic [15:0] encode_imm(input logic [2:0] rd, input logic [8:0] imm);
		return {op_ldi, rd, imm};
	endfunction

	function automatic logic [15:0] encode_branch(input logic [2:0] rd, input logic [5:0] off);
		return {op_beqz, rd, 3'b000, off};
	endfunction

	function automatic void model_reset();
		for (int r = 0; r < reg_count; r++)
			model_regs[r] = '0;
		model_pc = '0;
		model_halt = 1'b0;
	endfunction

	// ISA reference, one instruction per step until halt
	function automatic void run_model(input int steps);
		logic [word_width-1:0] ir;
		logic [2:0] rd;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [addr_width-1:0] next_pc;
		for (int n = 0; n < steps && !model_halt; n++) begin
			ir = model_mem[model_pc];
			rd = ir[11:9];
			rs = ir[8:6];
			rt = ir[5:3];
			next_pc = model_pc + 8'd1;
			case (ir[15:12])
				op_add: model_regs[rd] = model_regs[rs] + model_regs[rt];
				op_sub: model_regs[rd] = model_regs[rs] - model_regs[rt];
				op_and: model_regs[rd] = model_regs[rs] & model_regs[rt];
				op_ldi: model_regs[rd] = {7'd0, ir[8:0]};
				op_ld: model_regs[rd] = model_mem[model_regs[rs][7:0]];
				op_st: model_mem[model_regs[rs][7:0]] = model_regs[rd];
				op_beqz: begin
					if (model_regs[rd] == '0)
						next_pc = next_pc + {{2{ir[5]}}, ir[5:0]};
				end
				op_halt: begin
					model_halt = 1'b1;
					next_pc = model_pc;
				end
				default: next_pc = model_pc + 8'd1;
			endcase
			model_pc = next_pc;
		end
	endfunction

	task automatic send_bit(input logic value);
		uart_line = value;
		repeat (clks_per_bit) @(negedge MAX10_CLK1_50);
	endtask

	// 8N1 frame, LSB first
	task automatic send_byte(input logic [7:0] data, input logic stop);
		send_bit(1'b0);
		for (int n = 0; n < 8; n++)
			send_bit(data[n]);
		send_bit(stop);
		// Back to idle so the next start bit has a falling edge
		if (!stop)
			send_bit(1'b1);
	endtask

	// Sends the image, with a broken frame after word bad_after if it is in range
	task automatic load_program(input int bad_after);
		load_en = 1'b1;
		repeat (4) @(negedge MAX10_CLK1_50);
		foreach (image[i]) begin
			send_byte(image[i][15:8], 1'b1);
			send_byte(image[i][7:0], 1'b1);
			model_mem[i] = image[i];
			if (i == bad_after)
				send_byte(8'h5a, 1'b0);
		end
		repeat (4) @(negedge MAX10_CLK1_50);
		load_en = 1'b0;
		model_reset();
	endtask

	task automatic request_check(input logic hex_req, input logic led_req);
		exp_pc = model_pc;
		exp_instr = model_mem[model_pc];
		exp_r7_low = model_regs[7][7:0];
		exp_halt = model_halt;
		check_hex = hex_req;
		check_led = led_req;
		@(negedge MAX10_CLK1_50);
		check_hex = 1'b0;
		check_led = 1'b0;
	endtask

	// Key press, display settles within four clocks
	task automatic press_step();
		step_key_n = 1'b0;
		repeat (4) @(negedge MAX10_CLK1_50);
		run_model(1);
		request_check(1'b1, 1'b1);
		step_key_n = 1'b1;
		repeat (4) @(negedge MAX10_CLK1_50);
	endtask

	task automatic wait_halt(input int limit);
		int n;
		n = 0;
		while (ledr[9] !== 1'b1 && n < limit) begin
			@(negedge MAX10_CLK1_50);
			n++;
		end
		if (ledr[9] !== 1'b1) begin
			$display("Timed out after %0d clocks waiting for the halt LED", limit);
			timeouts++;
		end
	endtask

	task automatic build_fixed_program();
		image.delete();
		image.push_back(encode_imm(3'd1, 9'd5));
		image.push_back(encode_imm(3'd2, 9'd3));
		image.push_back(encode_reg(op_add, 3'd3, 3'd1, 3'd2));
		image.push_back(encode_reg(op_sub, 3'd4, 3'd1, 3'd2));
		image.push_back(encode_reg(op_and, 3'd5, 3'd3, 3'd1));
		image.push_back(encode_imm(3'd6, 9'h040));
		image.push_back(encode_reg(op_st, 3'd3, 3'd6, 3'd0));
		image.push_back(encode_reg(op_ld, 3'd7, 3'd6, 3'd0));
		// r5 is zero, skips the next word
		image.push_back(encode_branch(3'd5, 6'd1));
		image.push_back(encode_imm(3'd5, 9'd1));
		image.push_back(encode_reg(op_add, 3'd7, 3'd7, 3'd4));
		// Back to word 9 once, which sets r5 and ends the loop
		image.push_back(encode_branch(3'd5, 6'(-3)));
		image.push_back({op_halt, 12'h000});
	endtask

	task automatic build_short_program();
		image.delete();
		image.push_back(encode_imm(3'd7, 9'h02a));
		image.push_back(encode_imm(3'd1, 9'd7));
		image.push_back(encode_reg(op_sub, 3'd7, 3'd7, 3'd1));
		image.push_back(encode_reg(op_and, 3'd2, 3'd7, 3'd1));
		image.push_back(encode_reg(op_add, 3'd7, 3'd7, 3'd2));
		image.push_back({op_halt, 12'h000});
	endtask

	task automatic build_random_program(input int length);
		logic [3:0] code;
		logic [2:0] rd;
		image.delete();
		for (int i = 0; i < length - 1; i++) begin
			code = 4'($urandom % 16);
			rd = 3'($urandom % 8);
			// Memory ops and early halts fold into the no-op codes
			if (code == op_ld || code == op_st || code == op_halt)
				code = code + 4'd8;
			// Forward branches only, landing at most on the final halt
			if (code == op_beqz)
				image.push_back({code, rd, 3'b000, 6'($urandom % (length - 1 - i))});
			else
				image.push_back({code, rd, 9'($urandom)});
		end
		image.push_back({op_halt, 12'h000});
	endtask

	initial begin
		int total;
		void'($urandom(32'hb5093c00));
		rst = 1'b0;
		uart_line = 1'b1;
		step_key_n = 1'b1;
		debug_mode = 1'b0;
		load_en = 1'b1;
		check_hex = 1'b0;
		check_led = 1'b0;
		exp_pc = '0;
		exp_instr = '0;
		exp_r7_low = '0;
		exp_halt = 1'b0;
		timeouts = 0;
		for (int a = 0; a < mem_depth; a++)
			model_mem[a] = '0;
		model_reset();
		repeat (10) @(negedge MAX10_CLK1_50);
		rst = 1'b1;
		repeat (4) @(negedge MAX10_CLK1_50);

		// Blank digits with debug_mode low
		request_check(1'b1, 1'b0);

		// Fixed program, single-stepped to halt
		debug_mode = 1'b1;
		build_fixed_program();
		load_program(-1);
		request_check(1'b1, 1'b1);
		for (int n = 0; n < 32 && !model_halt; n++)
			press_step();
		press_step();
		press_step();

		// Reload after halt, with one broken frame in the stream
		build_short_program();
		load_program(1);
		request_check(1'b1, 1'b1);
		for (int n = 0; n < 16 && !model_halt; n++)
			press_step();

		// Random program, free running
		debug_mode = 1'b0;
		build_random_program(16);
		load_program(-1);
		run_model(64);
		wait_halt(4000);
		request_check(1'b1, 1'b1);
		repeat (4) @(negedge MAX10_CLK1_50);

		total = error_count + timeouts + int'(dut.u_cpu.cpu_checks.failures);
		$display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
			check_count, error_count, timeouts, dut.u_cpu.cpu_checks.failures);
		if (total == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== little_computer.f ====
little_computer_pkg.sv
uart_rx.sv
uart_word_loader.sv
step_control.sv
cpu_core.sv
unified_memory.sv
hex_display.sv
little_computer.sv
little_computer_checker.sv
little_computer_assert.sv
tb_little_computer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_little_computer
FILELIST  ?= little_computer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
